// ==== Bender.yml ====
package:
  name: i3c_tti

sources:
  - files:
      - rtl/tti_pkg.sv
      - rtl/tti_queue.sv
      - rtl/tti_csr.sv
      - rtl/tti_xfer_port.sv
      - rtl/tti_top.sv
  - target: test
    files:
      - testbench/tti_checker.sv
      - testbench/tti_assert.sv
      - testbench/tti_tb.sv

// ==== i3c_tti.f ====
rtl/tti_pkg.sv
rtl/tti_queue.sv
rtl/tti_csr.sv
rtl/tti_xfer_port.sv
rtl/tti_top.sv
testbench/tti_checker.sv
testbench/tti_assert.sv
testbench/tti_tb.sv

// ==== rtl/tti_csr.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response follows acceptance by one cycle with no back-pressure. TX writes
// to a full queue and any access during a flush are held off.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tti_csr (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire tti_pkg::tti_csr_req_t  csr_req_i,
    input  wire logic                   csr_req_valid_i,
    output logic                        csr_req_ready_o,
    output tti_pkg::tti_csr_rsp_t       csr_rsp_o,
    output logic                        csr_rsp_valid_o,
    output logic                        tx_desc_push_o,
    output logic                        tx_data_push_o,
    output logic [tti_pkg::DATA_W-1:0]  tx_wdata_o,
    input  wire logic                   tx_desc_full_i,
    input  wire logic                   tx_data_full_i,
    output logic                        rx_desc_pop_o,
    output logic                        rx_data_pop_o,
    input  wire logic [tti_pkg::DATA_W-1:0] rx_desc_i,
    input  wire logic [tti_pkg::DATA_W-1:0] rx_data_i,
    input  wire logic                   rx_desc_valid_i,
    input  wire logic                   rx_data_valid_i,
    input  wire logic [tti_pkg::NUM_QUEUES-1:0][tti_pkg::LEVEL_W-1:0] levels_i,
    input  wire logic [tti_pkg::NUM_QUEUES-1:0] thld_flags_i,
    output tti_pkg::tti_thld_t          thld_o,
    output logic [tti_pkg::NUM_QUEUES-1:0] flush_o
);

    import tti_pkg::*;

    tti_thld_t              thld_q;
    logic [NUM_QUEUES-1:0]  flush_q;
    tti_csr_rsp_t           rsp_d;
    tti_csr_rsp_t           rsp_q;
    logic                   rsp_valid_q;
    logic                   tx_full_stall;
    logic                   accept;
    logic                   wr_acc;
    logic                   rd_acc;

    assign tx_full_stall = csr_req_i.write &&
        ((csr_req_i.addr == ADDR_TX_DESC && tx_desc_full_i) ||
         (csr_req_i.addr == ADDR_TX_DATA && tx_data_full_i));

    // Hold off requests while a flush completes
    assign csr_req_ready_o = !tx_full_stall && (flush_q == '0);
    assign accept          = csr_req_valid_i && csr_req_ready_o;
    assign wr_acc          = accept && csr_req_i.write;
    assign rd_acc          = accept && !csr_req_i.write;

    assign tx_desc_push_o = wr_acc && (csr_req_i.addr == ADDR_TX_DESC);
    assign tx_data_push_o = wr_acc && (csr_req_i.addr == ADDR_TX_DATA);
    assign tx_wdata_o     = csr_req_i.wdata;
    assign rx_desc_pop_o  = rd_acc && (csr_req_i.addr == ADDR_RX_DESC) && rx_desc_valid_i;
    assign rx_data_pop_o  = rd_acc && (csr_req_i.addr == ADDR_RX_DATA) && rx_data_valid_i;

    always_comb begin
        rsp_d = '0;
        case (csr_req_i.addr)
            ADDR_TX_DESC, ADDR_TX_DATA: rsp_d.error = !csr_req_i.write;
            ADDR_RX_DESC: begin
                rsp_d.error = csr_req_i.write || !rx_desc_valid_i;
                rsp_d.rdata = rsp_d.error ? '0 : rx_desc_i;
            end
            ADDR_RX_DATA: begin
                rsp_d.error = csr_req_i.write || !rx_data_valid_i;
                rsp_d.rdata = rsp_d.error ? '0 : rx_data_i;
            end
            ADDR_THLD:    rsp_d.rdata = DATA_W'(thld_q);
            ADDR_RESET:   rsp_d.rdata = '0;
            ADDR_STATUS: begin
                rsp_d.error = csr_req_i.write;
                rsp_d.rdata = csr_req_i.write ? '0 : DATA_W'({levels_i, thld_flags_i});
            end
            default:      rsp_d.error = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
            flush_q     <= '0;
            thld_q      <= '{THLD_RESET, THLD_RESET, THLD_RESET, THLD_RESET};
        end else begin
            rsp_valid_q <= accept;
            // Self-clearing, one cycle wide
            flush_q <= (wr_acc && csr_req_i.addr == ADDR_RESET) ?
                       csr_req_i.wdata[NUM_QUEUES-1:0] : '0;
            if (wr_acc && csr_req_i.addr == ADDR_THLD) begin
                thld_q <= csr_req_i.wdata[$bits(tti_thld_t)-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_q <= rsp_d;
        end
    end

    assign csr_rsp_o       = rsp_q;
    assign csr_rsp_valid_o = rsp_valid_q;
    assign thld_o          = thld_q;
    assign flush_o         = flush_q;

endmodule

`default_nettype wire

// ==== rtl/tti_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, register map and types of the TTI. Queue index n matches
// bit n of the RESET register and of the STATUS flags.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package tti_pkg;

    localparam int DATA_W      = 32;
    localparam int QUEUE_DEPTH = 8;
    localparam int LEVEL_W     = 4;
    localparam int PTR_W       = $clog2(QUEUE_DEPTH);
    localparam int ADDR_W      = 3;
    localparam int LEN_W       = 16;
    localparam int NUM_QUEUES  = 4;

    // Register word indices
    localparam logic [ADDR_W-1:0] ADDR_TX_DESC = 3'd0;
    localparam logic [ADDR_W-1:0] ADDR_TX_DATA = 3'd1;
    localparam logic [ADDR_W-1:0] ADDR_RX_DESC = 3'd2;
    localparam logic [ADDR_W-1:0] ADDR_RX_DATA = 3'd3;
    localparam logic [ADDR_W-1:0] ADDR_THLD    = 3'd4;
    localparam logic [ADDR_W-1:0] ADDR_RESET   = 3'd5;
    localparam logic [ADDR_W-1:0] ADDR_STATUS  = 3'd6;

    // Queue indices for flush, levels and flags
    localparam int Q_TX_DESC = 0;
    localparam int Q_TX_DATA = 1;
    localparam int Q_RX_DESC = 2;
    localparam int Q_RX_DATA = 3;

    localparam logic [LEVEL_W-1:0] THLD_RESET = 4'd1;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
    } tti_csr_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              error;
    } tti_csr_rsp_t;

    typedef struct packed {
        logic [7:0]       cmd;
        logic [7:0]       reserved;
        logic [LEN_W-1:0] len;
    } tti_desc_t;

    // Software sees the raw word, the transfer port sees the fields
    typedef union packed {
        logic [DATA_W-1:0] raw;
        tti_desc_t         fields;
    } tti_desc_u;

    typedef struct packed {
        logic [LEVEL_W-1:0] tx_desc;
        logic [LEVEL_W-1:0] tx_data;
        logic [LEVEL_W-1:0] rx_desc;
        logic [LEVEL_W-1:0] rx_data;
    } tti_thld_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [7:0]        cmd;
        logic              last;
    } tti_beat_t;

endpackage

`default_nettype wire

// ==== rtl/tti_queue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Push into a full queue or pop from an empty one is ignored. Flush wins
// over push and pop in the same cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tti_queue (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire logic                         flush_i,
    input  wire logic                         push_i,
    input  wire logic [tti_pkg::DATA_W-1:0]   data_i,
    output logic                              full_o,
    input  wire logic                         pop_i,
    output logic [tti_pkg::DATA_W-1:0]        data_o,
    output logic                              valid_o,
    output logic [tti_pkg::LEVEL_W-1:0]       level_o,
    input  wire logic [tti_pkg::LEVEL_W-1:0]  thld_i,
    output logic                              thld_o
);

    import tti_pkg::*;

    logic [DATA_W-1:0]  mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [LEVEL_W-1:0] level_q;
    logic               do_push;
    logic               do_pop;

    assign full_o  = (level_q == LEVEL_W'(QUEUE_DEPTH));
    assign valid_o = (level_q != '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && valid_o;
    assign data_o  = mem_q[rd_ptr_q];
    assign level_o = level_q;
    assign thld_o  = (level_q >= thld_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Depth is a power of two, pointers wrap on their own
            case ({do_push, do_pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tti_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I3C target transaction interface without IBI queue or interrupts.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tti_top (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire tti_pkg::tti_csr_req_t  csr_req_i,
    input  wire logic                   csr_req_valid_i,
    output logic                        csr_req_ready_o,
    output tti_pkg::tti_csr_rsp_t       csr_rsp_o,
    output logic                        csr_rsp_valid_o,
    output tti_pkg::tti_beat_t          tx_beat_o,
    output logic                        tx_beat_valid_o,
    input  wire logic                   tx_beat_ready_i,
    input  wire tti_pkg::tti_beat_t     rx_beat_i,
    input  wire logic                   rx_beat_valid_i,
    output logic                        rx_beat_ready_o
);

    import tti_pkg::*;

    logic [DATA_W-1:0]                  tx_wdata;
    logic [DATA_W-1:0]                  tx_data_head;
    logic [DATA_W-1:0]                  rx_desc_head;
    logic [DATA_W-1:0]                  rx_data_head;
    tti_desc_u                          tx_desc_head;
    tti_desc_u                          rx_desc;
    tti_thld_t                          thld;
    logic [NUM_QUEUES-1:0]              flush;
    logic [NUM_QUEUES-1:0]              push;
    logic [NUM_QUEUES-1:0]              pop;
    logic [NUM_QUEUES-1:0]              full;
    logic [NUM_QUEUES-1:0]              valid;
    logic [NUM_QUEUES-1:0]              flags;
    logic [NUM_QUEUES-1:0][LEVEL_W-1:0] levels;

    tti_csr u_csr (
        .clk_i, .rst_ni, .csr_req_i, .csr_req_valid_i, .csr_req_ready_o,
        .csr_rsp_o, .csr_rsp_valid_o,
        .tx_desc_push_o (push[Q_TX_DESC]),  .tx_data_push_o (push[Q_TX_DATA]),
        .tx_wdata_o     (tx_wdata),
        .tx_desc_full_i (full[Q_TX_DESC]),  .tx_data_full_i (full[Q_TX_DATA]),
        .rx_desc_pop_o  (pop[Q_RX_DESC]),   .rx_data_pop_o  (pop[Q_RX_DATA]),
        .rx_desc_i      (rx_desc_head),     .rx_data_i      (rx_data_head),
        .rx_desc_valid_i(valid[Q_RX_DESC]), .rx_data_valid_i(valid[Q_RX_DATA]),
        .levels_i       (levels),           .thld_flags_i   (flags),
        .thld_o         (thld),             .flush_o        (flush)
    );

    tti_queue u_tx_desc_q (
        .clk_i, .rst_ni, .flush_i(flush[Q_TX_DESC]),
        .push_i(push[Q_TX_DESC]), .data_i(tx_wdata), .full_o(full[Q_TX_DESC]),
        .pop_i(pop[Q_TX_DESC]), .data_o(tx_desc_head), .valid_o(valid[Q_TX_DESC]),
        .level_o(levels[Q_TX_DESC]), .thld_i(thld.tx_desc), .thld_o(flags[Q_TX_DESC])
    );

    tti_queue u_tx_data_q (
        .clk_i, .rst_ni, .flush_i(flush[Q_TX_DATA]),
        .push_i(push[Q_TX_DATA]), .data_i(tx_wdata), .full_o(full[Q_TX_DATA]),
        .pop_i(pop[Q_TX_DATA]), .data_o(tx_data_head), .valid_o(valid[Q_TX_DATA]),
        .level_o(levels[Q_TX_DATA]), .thld_i(thld.tx_data), .thld_o(flags[Q_TX_DATA])
    );

    tti_queue u_rx_desc_q (
        .clk_i, .rst_ni, .flush_i(flush[Q_RX_DESC]),
        .push_i(push[Q_RX_DESC]), .data_i(rx_desc), .full_o(full[Q_RX_DESC]),
        .pop_i(pop[Q_RX_DESC]), .data_o(rx_desc_head), .valid_o(valid[Q_RX_DESC]),
        .level_o(levels[Q_RX_DESC]), .thld_i(thld.rx_desc), .thld_o(flags[Q_RX_DESC])
    );

    tti_queue u_rx_data_q (
        .clk_i, .rst_ni, .flush_i(flush[Q_RX_DATA]),
        .push_i(push[Q_RX_DATA]), .data_i(rx_beat_i.data), .full_o(full[Q_RX_DATA]),
        .pop_i(pop[Q_RX_DATA]), .data_o(rx_data_head), .valid_o(valid[Q_RX_DATA]),
        .level_o(levels[Q_RX_DATA]), .thld_i(thld.rx_data), .thld_o(flags[Q_RX_DATA])
    );

    tti_xfer_port u_xfer_port (
        .clk_i, .rst_ni,
        .tx_desc_i      (tx_desc_head),  .tx_desc_valid_i(valid[Q_TX_DESC]),
        .tx_desc_pop_o  (pop[Q_TX_DESC]),
        .tx_data_i      (tx_data_head),  .tx_data_valid_i(valid[Q_TX_DATA]),
        .tx_data_pop_o  (pop[Q_TX_DATA]),
        .tx_beat_o, .tx_beat_valid_o, .tx_beat_ready_i,
        .rx_beat_i, .rx_beat_valid_i, .rx_beat_ready_o,
        .rx_data_push_o (push[Q_RX_DATA]), .rx_data_full_i(full[Q_RX_DATA]),
        .rx_desc_push_o (push[Q_RX_DESC]), .rx_desc_o     (rx_desc),
        .rx_desc_full_i (full[Q_RX_DESC])
    );

endmodule

`default_nettype wire

// ==== rtl/tti_xfer_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TX beats need the descriptor and a data word at the queue heads. A zero
// length descriptor is dropped. RX descriptors are pushed with the last beat.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tti_xfer_port (
    input  wire logic                        clk_i,
    input  wire logic                        rst_ni,
    input  wire tti_pkg::tti_desc_u          tx_desc_i,
    input  wire logic                        tx_desc_valid_i,
    output logic                             tx_desc_pop_o,
    input  wire logic [tti_pkg::DATA_W-1:0]  tx_data_i,
    input  wire logic                        tx_data_valid_i,
    output logic                             tx_data_pop_o,
    output tti_pkg::tti_beat_t               tx_beat_o,
    output logic                             tx_beat_valid_o,
    input  wire logic                        tx_beat_ready_i,
    input  wire tti_pkg::tti_beat_t          rx_beat_i,
    input  wire logic                        rx_beat_valid_i,
    output logic                             rx_beat_ready_o,
    output logic                             rx_data_push_o,
    input  wire logic                        rx_data_full_i,
    output logic                             rx_desc_push_o,
    output tti_pkg::tti_desc_u               rx_desc_o,
    input  wire logic                        rx_desc_full_i
);

    import tti_pkg::*;

    logic             tx_busy_q;
    logic [LEN_W-1:0] tx_rem_q;
    logic [LEN_W-1:0] tx_rem;
    logic             tx_last;
    logic             tx_fire;
    logic             tx_drop;
    logic [LEN_W-1:0] rx_cnt_q;
    logic             rx_fire;

    // Words left in the current descriptor, taken from len when idle
    assign tx_rem  = tx_busy_q ? tx_rem_q : tx_desc_i.fields.len;
    assign tx_last = (tx_rem == LEN_W'(1));
    assign tx_drop = tx_desc_valid_i && !tx_busy_q && (tx_rem == '0);

    assign tx_beat_valid_o = tx_desc_valid_i && tx_data_valid_i && (tx_rem != '0);
    assign tx_fire         = tx_beat_valid_o && tx_beat_ready_i;
    assign tx_data_pop_o   = tx_fire;
    assign tx_desc_pop_o   = (tx_fire && tx_last) || tx_drop;

    assign tx_beat_o = '{data: tx_data_i, cmd: tx_desc_i.fields.cmd, last: tx_last};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tx_busy_q <= 1'b0;
            tx_rem_q  <= '0;
        end else if (tx_fire) begin
            tx_busy_q <= !tx_last;
            tx_rem_q  <= tx_rem - 1'b1;
        end
    end

    // A last beat also needs room for its descriptor
    assign rx_beat_ready_o = !rx_data_full_i && !(rx_beat_i.last && rx_desc_full_i);
    assign rx_fire         = rx_beat_valid_i && rx_beat_ready_o;
    assign rx_data_push_o  = rx_fire;
    assign rx_desc_push_o  = rx_fire && rx_beat_i.last;

    always_comb begin
        rx_desc_o.fields = '{
            cmd:      rx_beat_i.cmd,
            reserved: 8'h00,
            len:      rx_cnt_q + 1'b1
        };
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rx_cnt_q <= '0;
        end else if (rx_fire) begin
            rx_cnt_q <= rx_beat_i.last ? '0 : rx_cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tti_assert.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound into tti_top. fail_cnt holds the number of failed assertions.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tti_assert (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire tti_pkg::tti_csr_req_t req_i,
    input  wire logic                  req_valid_i,
    input  wire logic                  req_ready_i,
    input  wire logic                  rsp_valid_i,
    input  wire tti_pkg::tti_beat_t    tx_beat_i,
    input  wire logic                  tx_valid_i,
    input  wire logic                  tx_ready_i,
    input  wire logic                  rx_ready_i
);

    int fail_cnt = 0;

    req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
    else begin
        fail_cnt++;
        $error("stalled CSR request changed");
    end

    tx_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_beat_i))
    else begin
        fail_cnt++;
        $error("offered TX beat changed before it was taken");
    end

    // Response exactly one cycle after acceptance
    rsp_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_i == $past(req_valid_i && req_ready_i))
    else begin
        fail_cnt++;
        $error("CSR response valid out of step with acceptance");
    end

    reset_state: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !rsp_valid_i && !tx_valid_i && req_ready_i && rx_ready_i)
    else begin
        fail_cnt++;
        $error("handshake outputs wrong after reset");
    end

endmodule

bind tti_top tti_assert u_assert (
    .clk_i,
    .rst_ni,
    .req_i       (csr_req_i),
    .req_valid_i (csr_req_valid_i),
    .req_ready_i (csr_req_ready_o),
    .rsp_valid_i (csr_rsp_valid_o),
    .tx_beat_i   (tx_beat_o),
    .tx_valid_i  (tx_beat_valid_o),
    .tx_ready_i  (tx_beat_ready_i),
    .rx_ready_i  (rx_beat_ready_o)
);

`default_nettype wire

// ==== testbench/tti_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CSR responses match requests in order, TX beats in arrival order. Write
// responses are compared on the error bit only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tti_checker (
    input  wire logic                  clk_i,
    input  wire tti_pkg::tti_csr_rsp_t csr_rsp_i,
    input  wire logic                  csr_rsp_valid_i,
    input  wire tti_pkg::tti_beat_t    tx_beat_i,
    input  wire logic                  tx_beat_valid_i,
    input  wire logic                  tx_beat_ready_i
);

    import tti_pkg::*;

    localparam int TIMEOUT = 200;

    typedef struct {
        string        name;
        logic         chk_data;
        tti_csr_rsp_t exp;
    } rsp_exp_t;

    rsp_exp_t  rsp_q[$];
    rsp_exp_t  pend;
    tti_beat_t tx_seen[$];
    int        pass_cnt = 0;
    int        fail_cnt = 0;

    function automatic void compare(input string name, input logic [63:0] exp,
                                    input logic [63:0] act);
        if (exp === act) begin
            pass_cnt++;
            $display("ok  %s", name);
        end else begin
            fail_cnt++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endfunction

    function automatic void report_failure(input string msg);
        fail_cnt++;
        $display("ERROR: %s", msg);
    endfunction

    function automatic void expect_rsp(input string name, input logic chk_data,
                                       input tti_csr_rsp_t exp);
        rsp_q.push_back('{name: name, chk_data: chk_data, exp: exp});
    endfunction

    task automatic check_tx(input string name, input tti_beat_t exp);
        int n;
        n = 0;
        while (tx_seen.size() == 0 && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (tx_seen.size() == 0) begin
            report_failure({name, ": no TX beat arrived in time"});
        end else begin
            compare(name, 64'(exp), 64'(tx_seen.pop_front()));
        end
    endtask

    // Mid-cycle sampling, outputs are settled here
    always @(negedge clk_i) begin
        if (tx_beat_valid_i && tx_beat_ready_i) begin
            tx_seen.push_back(tx_beat_i);
        end
        if (csr_rsp_valid_i) begin
            if (rsp_q.size() == 0) begin
                report_failure("CSR response came without a request");
            end else begin
                pend = rsp_q.pop_front();
                if (pend.chk_data) begin
                    compare(pend.name, 64'(pend.exp), 64'(csr_rsp_i));
                end else begin
                    compare(pend.name, 64'(pend.exp.error), 64'(csr_rsp_i.error));
                end
            end
        end
    end

    function automatic void print_summary();
        if (rsp_q.size() != 0) begin
            report_failure("a CSR response never arrived");
        end
        if (tx_seen.size() != 0) begin
            report_failure("TX beats arrived that no step expected");
        end
        $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
    endfunction

endmodule

`default_nettype wire

// ==== testbench/tti_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Steps run in table order. TX ready is random unless a step holds it low.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tti_tb;

    import tti_pkg::*;

    localparam int TIMEOUT      = 200;
    localparam int STALL_CYCLES = 20;

    typedef enum logic [2:0] {CSR_WR, CSR_RD, CSR_STALL, RX_BEAT, TX_BEAT, TX_HOLD} step_kind_e;

    // flag is the beat's last bit, the expected read error, or the hold level
    typedef struct {
        step_kind_e        kind;
        string             name;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [7:0]        cmd;
        logic              flag;
    } step_t;

    logic         clk = 1'b0;
    logic         rst_n;
    tti_csr_req_t csr_req;
    logic         csr_req_valid;
    logic         csr_req_ready;
    tti_csr_rsp_t csr_rsp;
    logic         csr_rsp_valid;
    tti_beat_t    tx_beat;
    logic         tx_beat_valid;
    logic         tx_beat_ready;
    tti_beat_t    rx_beat;
    logic         rx_beat_valid;
    logic         rx_beat_ready;
    logic         tx_hold;
    integer       seed = 44;
    int           rnd;
    step_t        steps[$];

    tti_top u_dut (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .csr_req_i       (csr_req),
        .csr_req_valid_i (csr_req_valid),
        .csr_req_ready_o (csr_req_ready),
        .csr_rsp_o       (csr_rsp),
        .csr_rsp_valid_o (csr_rsp_valid),
        .tx_beat_o       (tx_beat),
        .tx_beat_valid_o (tx_beat_valid),
        .tx_beat_ready_i (tx_beat_ready),
        .rx_beat_i       (rx_beat),
        .rx_beat_valid_i (rx_beat_valid),
        .rx_beat_ready_o (rx_beat_ready)
    );

    tti_checker u_checker (
        .clk_i           (clk),
        .csr_rsp_i       (csr_rsp),
        .csr_rsp_valid_i (csr_rsp_valid),
        .tx_beat_i       (tx_beat),
        .tx_beat_valid_i (tx_beat_valid),
        .tx_beat_ready_i (tx_beat_ready)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        rnd = $random(seed);
        tx_beat_ready <= !tx_hold && rnd[0];
    end

    function automatic void add_step(input step_kind_e kind, input string name,
                                     input logic [ADDR_W-1:0] addr,
                                     input logic [DATA_W-1:0] data,
                                     input logic [7:0] cmd, input logic flag);
        steps.push_back('{kind: kind, name: name, addr: addr, data: data, cmd: cmd,
                          flag: flag});
    endfunction

    // STATUS holds the flags in 3:0 and the levels above, tx_desc lowest
    function automatic logic [DATA_W-1:0] status_word(input int txd, input int txw,
                                                      input int rxd, input int rxw,
                                                      input int rxw_thld);
        logic [3:0] flags;
        flags = {rxw >= rxw_thld, rxd >= 1, txw >= 1, txd >= 1};
        return {12'h000, 4'(rxw), 4'(rxd), 4'(txw), 4'(txd), flags};
    endfunction

    function automatic void build_table();
        add_step(CSR_WR, "tx desc a5 len 3", ADDR_TX_DESC, 32'hA500_0003, 8'h00, 1'b0);
        for (int i = 1; i <= 3; i++) begin
            add_step(CSR_WR, $sformatf("tx data %0d", i), ADDR_TX_DATA, 32'h1111_0000 + i,
                     8'h00, 1'b0);
        end
        for (int i = 1; i <= 3; i++) begin
            add_step(TX_BEAT, $sformatf("tx beat %0d", i), '0, 32'h1111_0000 + i, 8'hA5,
                     i == 3);
        end
        add_step(RX_BEAT, "rx beat 1", '0, 32'h2222_0001, 8'h3C, 1'b0);
        add_step(RX_BEAT, "rx beat 2", '0, 32'h2222_0002, 8'h3C, 1'b1);
        add_step(CSR_RD, "rx data 1", ADDR_RX_DATA, 32'h2222_0001, 8'h00, 1'b0);
        add_step(CSR_RD, "rx data 2", ADDR_RX_DATA, 32'h2222_0002, 8'h00, 1'b0);
        add_step(CSR_RD, "rx desc 3c len 2", ADDR_RX_DESC, 32'h3C00_0002, 8'h00, 1'b0);
        add_step(CSR_RD, "rx data empty", ADDR_RX_DATA, 32'h0, 8'h00, 1'b1);
        add_step(CSR_RD, "unknown address", 3'd7, 32'h0, 8'h00, 1'b1);
        add_step(CSR_RD, "thld after reset", ADDR_THLD, 32'h0000_1111, 8'h00, 1'b0);
        // Threshold 2 for rx_data and 1 for the other queues
        add_step(CSR_WR, "thld write", ADDR_THLD, 32'h0000_1112, 8'h00, 1'b0);
        add_step(CSR_RD, "thld readback", ADDR_THLD, 32'h0000_1112, 8'h00, 1'b0);
        add_step(RX_BEAT, "thld beat 1", '0, 32'h4444_0001, 8'h10, 1'b0);
        add_step(CSR_RD, "status one beat", ADDR_STATUS, status_word(0, 0, 0, 1, 2), 8'h00, 1'b0);
        add_step(RX_BEAT, "thld beat 2", '0, 32'h4444_0002, 8'h10, 1'b1);
        add_step(CSR_RD, "status two beats", ADDR_STATUS, status_word(0, 0, 1, 2, 2), 8'h00,
                 1'b0);
        add_step(RX_BEAT, "flush beat", '0, 32'h5555_0001, 8'h20, 1'b0);
        add_step(CSR_RD, "status three beats", ADDR_STATUS, status_word(0, 0, 1, 3, 2), 8'h00,
                 1'b0);
        add_step(CSR_WR, "flush rx data", ADDR_RESET, 32'h0000_0008, 8'h00, 1'b0);
        add_step(CSR_RD, "reset reads zero", ADDR_RESET, 32'h0, 8'h00, 1'b0);
        add_step(CSR_RD, "status after flush", ADDR_STATUS, status_word(0, 0, 1, 0, 2), 8'h00,
                 1'b0);
        add_step(CSR_RD, "rx data flushed", ADDR_RX_DATA, 32'h0, 8'h00, 1'b1);
        // Back-pressure with the TX sink held off
        add_step(TX_HOLD, "hold tx sink", '0, '0, 8'h00, 1'b1);
        for (int i = 1; i <= 8; i++) begin
            add_step(CSR_WR, $sformatf("fill data %0d", i), ADDR_TX_DATA, 32'h6666_0000 + i,
                     8'h00, 1'b0);
        end
        add_step(CSR_WR, "desc with full data", ADDR_TX_DESC, 32'h5A00_0008, 8'h00, 1'b0);
        add_step(CSR_STALL, "ninth data", ADDR_TX_DATA, 32'h6666_0009, 8'h00, 1'b0);
        for (int i = 1; i <= 8; i++) begin
            add_step(TX_BEAT, $sformatf("drain beat %0d", i), '0, 32'h6666_0000 + i, 8'h5A,
                     i == 8);
        end
    endfunction

    task automatic csr_access(input string name, input logic wr,
                              input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic chk, input tti_csr_rsp_t exp, input int stall);
        int n;
        n = 0;
        @(posedge clk);
        csr_req       <= '{addr: addr, write: wr, wdata: data};
        csr_req_valid <= 1'b1;
        @(negedge clk);
        // A stalled write has to stay unaccepted while the sink is held
        for (int i = 0; i < stall && !csr_req_ready; i++) begin
            @(negedge clk);
        end
        if (stall > 0) begin
            u_checker.compare({name, " held off"}, 64'(0), 64'(csr_req_ready));
            tx_hold <= 1'b0;
        end
        while (!csr_req_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (csr_req_ready) begin
            u_checker.expect_rsp(name, chk, exp);
        end else begin
            u_checker.report_failure({name, ": CSR request was never accepted"});
        end
        @(posedge clk);
        csr_req_valid <= 1'b0;
    endtask

    task automatic send_rx_beat(input string name, input tti_beat_t beat);
        int n;
        n = 0;
        @(posedge clk);
        rx_beat       <= beat;
        rx_beat_valid <= 1'b1;
        @(negedge clk);
        while (!rx_beat_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rx_beat_ready) begin
            u_checker.report_failure({name, ": RX beat was never taken"});
        end
        @(posedge clk);
        rx_beat_valid <= 1'b0;
    endtask

    initial begin
        step_t s;
        rst_n         = 1'b0;
        csr_req       = '0;
        csr_req_valid = 1'b0;
        rx_beat       = '0;
        rx_beat_valid = 1'b0;
        tx_beat_ready = 1'b0;
        tx_hold       = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        foreach (steps[i]) begin
            s = steps[i];
            case (s.kind)
                CSR_WR:    csr_access(s.name, 1'b1, s.addr, s.data, 1'b0, '0, 0);
                CSR_STALL: csr_access(s.name, 1'b1, s.addr, s.data, 1'b0, '0, STALL_CYCLES);
                CSR_RD: begin
                    csr_access(s.name, 1'b0, s.addr, '0, 1'b1,
                               '{rdata: s.data, error: s.flag}, 0);
                end
                RX_BEAT: send_rx_beat(s.name, '{data: s.data, cmd: s.cmd, last: s.flag});
                TX_BEAT: u_checker.check_tx(s.name, '{data: s.data, cmd: s.cmd, last: s.flag});
                default: begin
                    @(posedge clk);
                    tx_hold <= s.flag;
                end
            endcase
        end
        repeat (4) @(posedge clk);
        u_checker.print_summary();
        if (u_checker.fail_cnt == 0 && u_dut.u_assert.fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
